// File: verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // other opcode values dispatch straight back to fetch
    typedef enum logic [3:0] {
        op_add  = 4'h1,
        op_addi = 4'h2,
        op_lw   = 4'h3,
        op_sw   = 4'h4
    } opcode_t;

    // instruction word layout with the msb first
    typedef struct packed {
        opcode_t     opcode;
        logic [12:0] imm;
        reg_addr_t   rd;
        reg_addr_t   rs2;
        reg_addr_t   rs1;
    } instr_t;

    // pc step per instruction
    localparam word_t WORD_BYTES = 32'd4;

endpackage

// File: verilog/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // declaration order gives the sequential successor
    typedef enum logic [4:0] {
        f0, f1, f2,
        a0, a1, a2,
        ai0, ai1, ai2,
        l0, l1, l2, l3,
        s0, s1, s2, s3, s4
    } ustate_t;

    typedef enum logic [1:0] {
        seq_next,
        seq_dispatch,
        seq_fetch
    } next_t;

    // which ir field addresses the register file
    typedef enum logic [1:0] {
        sel_none,
        sel_rs1,
        sel_rs2,
        sel_rd
    } reg_sel_t;

    typedef struct packed {
        // bus drivers
        logic     pc_bus_en;
        logic     alu_bus_en;
        logic     imm_bus_en;
        logic     rf_bus_en;
        logic     mem_bus_en;
        // latch loads
        logic     pc_en;
        logic     a_en;
        logic     b_en;
        logic     ir_en;
        logic     wd_en;
        logic     mar_en;
        logic     rf_wen;
        reg_sel_t rf_sel;
        logic     alu_add_b;
        logic     mem_rd;
        logic     mem_wr;
        next_t    next;
    } ctrl_word_t;

endpackage

// File: verilog/ctrl_if.sv
`timescale 1ns/10ps

interface ctrl_if;

    cpu_ctrl_pkg::ctrl_word_t cw;
    cpu_isa_pkg::instr_t      ir;
    // memory state not finished yet
    logic                     stall;
    // qualifies every latch and upc update
    logic                     advance;

    modport store (output cw);

    modport seq (input cw, input ir, input stall, output advance);

    modport dp (input cw, input advance, output ir);

    modport mem (input cw, output stall);

endinterface

// File: verilog/micro_sequencer.sv
`timescale 1ns/10ps

module micro_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    output cpu_ctrl_pkg::ustate_t upc,
    ctrl_if.seq                   ctl
);

    cpu_ctrl_pkg::ustate_t upc_nxt;
    cpu_ctrl_pkg::ustate_t dispatch_tgt;

    // memory states hold until the port is done
    assign ctl.advance = !ctl.stall;

    // opcode dispatch
    always_comb begin
        case (ctl.ir.opcode)
            cpu_isa_pkg::op_add:  dispatch_tgt = cpu_ctrl_pkg::a0;
            cpu_isa_pkg::op_addi: dispatch_tgt = cpu_ctrl_pkg::ai0;
            cpu_isa_pkg::op_lw:   dispatch_tgt = cpu_ctrl_pkg::l0;
            cpu_isa_pkg::op_sw:   dispatch_tgt = cpu_ctrl_pkg::s0;
            default:              dispatch_tgt = cpu_ctrl_pkg::f0;
        endcase
    end

    always_comb begin
        case (ctl.cw.next)
            cpu_ctrl_pkg::seq_dispatch: upc_nxt = dispatch_tgt;
            cpu_ctrl_pkg::seq_fetch:    upc_nxt = cpu_ctrl_pkg::f0;
            default:                    upc_nxt = cpu_ctrl_pkg::ustate_t'(upc + 5'd1);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upc <= cpu_ctrl_pkg::f0;
        end else if (ctl.advance) begin
            upc <= upc_nxt;
        end
    end

    // the last micro-state must always return to fetch
    a_upc_legal: assert property (@(posedge clk) disable iff (!rst_n)
        upc <= cpu_ctrl_pkg::s4);

endmodule

// File: verilog/control_store.sv
`timescale 1ns/10ps

module control_store (
    input cpu_ctrl_pkg::ustate_t upc,
    ctrl_if.store                ctl
);

    cpu_ctrl_pkg::ctrl_word_t cw;

    assign ctl.cw = cw;

    always_comb begin
        cw      = '0;
        cw.next = cpu_ctrl_pkg::seq_next;
        case (upc)
            ////////////////////////////////////////
            // fetch
            cpu_ctrl_pkg::f0: begin
                cw.pc_bus_en = 1'b1;
                cw.a_en      = 1'b1;
                cw.mar_en    = 1'b1;
            end
            cpu_ctrl_pkg::f1: begin
                cw.mem_bus_en = 1'b1;
                cw.ir_en      = 1'b1;
                cw.mem_rd     = 1'b1;
            end
            // pc + 4 while decoding
            cpu_ctrl_pkg::f2: begin
                cw.alu_bus_en = 1'b1;
                cw.pc_en      = 1'b1;
                cw.next       = cpu_ctrl_pkg::seq_dispatch;
            end
            ////////////////////////////////////////
            // operand gather
            cpu_ctrl_pkg::a0, cpu_ctrl_pkg::ai0, cpu_ctrl_pkg::l0, cpu_ctrl_pkg::s1: begin
                cw.rf_bus_en = 1'b1;
                cw.rf_sel    = cpu_ctrl_pkg::sel_rs1;
                cw.a_en      = 1'b1;
            end
            cpu_ctrl_pkg::a1: begin
                cw.rf_bus_en = 1'b1;
                cw.rf_sel    = cpu_ctrl_pkg::sel_rs2;
                cw.b_en      = 1'b1;
            end
            cpu_ctrl_pkg::ai1, cpu_ctrl_pkg::l1, cpu_ctrl_pkg::s2: begin
                cw.imm_bus_en = 1'b1;
                cw.b_en       = 1'b1;
            end
            cpu_ctrl_pkg::s0: begin
                cw.rf_bus_en = 1'b1;
                cw.rf_sel    = cpu_ctrl_pkg::sel_rs2;
                cw.wd_en     = 1'b1;
            end
            ////////////////////////////////////////
            // execute and writeback
            cpu_ctrl_pkg::a2, cpu_ctrl_pkg::ai2: begin
                cw.alu_bus_en = 1'b1;
                cw.alu_add_b  = 1'b1;
                cw.rf_wen     = 1'b1;
                cw.rf_sel     = cpu_ctrl_pkg::sel_rd;
                cw.next       = cpu_ctrl_pkg::seq_fetch;
            end
            // effective address
            cpu_ctrl_pkg::l2, cpu_ctrl_pkg::s3: begin
                cw.alu_bus_en = 1'b1;
                cw.alu_add_b  = 1'b1;
                cw.mar_en     = 1'b1;
            end
            cpu_ctrl_pkg::l3: begin
                cw.mem_bus_en = 1'b1;
                cw.mem_rd     = 1'b1;
                cw.rf_wen     = 1'b1;
                cw.rf_sel     = cpu_ctrl_pkg::sel_rd;
                cw.next       = cpu_ctrl_pkg::seq_fetch;
            end
            cpu_ctrl_pkg::s4: begin
                cw.mem_wr = 1'b1;
                cw.next   = cpu_ctrl_pkg::seq_fetch;
            end
            default: begin
                cw.next = cpu_ctrl_pkg::seq_fetch;
            end
        endcase
    end

endmodule

// File: verilog/datapath.sv
`timescale 1ns/10ps

module datapath #(
    parameter cpu_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    ctrl_if.dp                     ctl,
    output cpu_isa_pkg::reg_addr_t rf_sel_addr,
    input  cpu_isa_pkg::word_t     rf_rdata,
    output cpu_isa_pkg::word_t     bus,
    input  cpu_isa_pkg::word_t     mem_rdata_q,
    output cpu_isa_pkg::word_t     mar,
    output cpu_isa_pkg::word_t     wd
);

    cpu_isa_pkg::word_t  pc;
    cpu_isa_pkg::word_t  a;
    cpu_isa_pkg::word_t  b;
    cpu_isa_pkg::instr_t ir;
    cpu_isa_pkg::word_t  imm_ext;
    cpu_isa_pkg::word_t  alu_out;

    assign ctl.ir  = ir;
    assign imm_ext = {{19{ir.imm[12]}}, ir.imm};
    // increment unless the sum is asked for
    assign alu_out = a + (ctl.cw.alu_add_b ? b : cpu_isa_pkg::WORD_BYTES);

    always_comb begin
        case (ctl.cw.rf_sel)
            cpu_ctrl_pkg::sel_rs1: rf_sel_addr = ir.rs1;
            cpu_ctrl_pkg::sel_rs2: rf_sel_addr = ir.rs2;
            cpu_ctrl_pkg::sel_rd:  rf_sel_addr = ir.rd;
            default:               rf_sel_addr = '0;
        endcase
    end

    ////////////////////////////////////////
    // single bus with one driver per state
    always_comb begin
        if (ctl.cw.pc_bus_en)
            bus = pc;
        else if (ctl.cw.alu_bus_en)
            bus = alu_out;
        else if (ctl.cw.imm_bus_en)
            bus = imm_ext;
        else if (ctl.cw.rf_bus_en)
            bus = rf_rdata;
        else if (ctl.cw.mem_bus_en)
            bus = mem_rdata_q;
        else
            bus = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (ctl.advance && ctl.cw.pc_en) begin
            pc <= bus;
        end
    end

    // operand and address latches
    always_ff @(posedge clk) begin
        if (ctl.advance) begin
            if (ctl.cw.a_en)
                a <= bus;
            if (ctl.cw.b_en)
                b <= bus;
            if (ctl.cw.ir_en)
                ir <= bus;
            if (ctl.cw.wd_en)
                wd <= bus;
            if (ctl.cw.mar_en)
                mar <= bus;
        end
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    ctrl_if.dp                     ctl,
    input  cpu_isa_pkg::reg_addr_t addr,
    input  cpu_isa_pkg::word_t     wdata,
    output cpu_isa_pkg::word_t     rdata
);

    cpu_isa_pkg::word_t regs [NUM_REGS];

    // indices past the array read as zero
    assign rdata = (addr < NUM_REGS) ? regs[addr] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (ctl.advance && ctl.cw.rf_wen) begin
            regs[addr] <= wdata;
        end
    end

    // ir field picked by the datapath must fit this file
    a_wr_idx: assert property (@(posedge clk) disable iff (!rst_n)
        (ctl.advance && ctl.cw.rf_wen) |-> (addr < NUM_REGS));

endmodule

// File: verilog/mem_port.sv
`timescale 1ns/10ps

module mem_port (
    input  logic               clk,
    input  logic               rst_n,
    ctrl_if.mem                ctl,
    input  cpu_isa_pkg::word_t mar,
    input  cpu_isa_pkg::word_t wd,
    output cpu_isa_pkg::word_t rdata_q,
    output logic               mem_req,
    output logic               mem_we,
    output cpu_isa_pkg::word_t mem_addr,
    output cpu_isa_pkg::word_t mem_wdata,
    input  cpu_isa_pkg::word_t mem_rdata,
    input  logic               mem_ack
);

    typedef enum logic [1:0] {st_idle, st_req, st_ack_low, st_done} state_t;

    state_t state;
    logic   active;

    assign active    = ctl.cw.mem_rd || ctl.cw.mem_wr;
    // released for one cycle once all four phases are over
    assign ctl.stall = active && (state != st_done);
    assign mem_addr  = mar;
    assign mem_wdata = wd;

    ////////////////////////////////////////
    // four-phase handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (active && !mem_ack) begin
                        state   <= st_req;
                        mem_req <= 1'b1;
                        mem_we  <= ctl.cw.mem_wr;
                    end
                end
                st_req: begin
                    if (mem_ack) begin
                        state   <= st_ack_low;
                        mem_req <= 1'b0;
                        mem_we  <= 1'b0;
                    end
                end
                st_ack_low: begin
                    if (!mem_ack)
                        state <= st_done;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // read data is only valid while ack is high
    always_ff @(posedge clk) begin
        if (state == st_req && mem_ack && !mem_we)
            rdata_q <= mem_rdata;
    end

    // mar and wd are frozen by the stall
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && $past(mem_req)) |-> ($stable(mem_addr) && $stable(mem_wdata)));

    a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !mem_ack);

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
    parameter cpu_isa_pkg::word_t RESET_PC = 32'h0000_0000,
    parameter int                 NUM_REGS = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic               mem_req,
    output logic               mem_we,
    output cpu_isa_pkg::word_t mem_addr,
    output cpu_isa_pkg::word_t mem_wdata,
    input  cpu_isa_pkg::word_t mem_rdata,
    input  logic               mem_ack
);

    cpu_ctrl_pkg::ustate_t  upc;
    cpu_isa_pkg::reg_addr_t rf_sel_addr;
    cpu_isa_pkg::word_t     rf_rdata;
    cpu_isa_pkg::word_t     bus;
    cpu_isa_pkg::word_t     mem_rdata_q;
    cpu_isa_pkg::word_t     mar;
    cpu_isa_pkg::word_t     wd;

    ctrl_if u_ctl ();

    // decode
    micro_sequencer u_seq (.clk(clk), .rst_n(rst_n), .upc(upc), .ctl(u_ctl.seq));

    control_store u_store (.upc(upc), .ctl(u_ctl.store));

    // execute
    datapath #(.RESET_PC(RESET_PC)) u_dp (
        .clk(clk), .rst_n(rst_n), .ctl(u_ctl.dp),
        .rf_sel_addr(rf_sel_addr), .rf_rdata(rf_rdata), .bus(bus),
        .mem_rdata_q(mem_rdata_q), .mar(mar), .wd(wd)
    );

    reg_file #(.NUM_REGS(NUM_REGS)) u_rf (
        .clk(clk), .rst_n(rst_n), .ctl(u_ctl.dp),
        .addr(rf_sel_addr), .wdata(bus), .rdata(rf_rdata)
    );

    mem_port u_mem (
        .clk(clk), .rst_n(rst_n), .ctl(u_ctl.mem),
        .mar(mar), .wd(wd), .rdata_q(mem_rdata_q),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
    );

endmodule

// File: bench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int NUM_ROWS = 5;

row_t rows [NUM_ROWS];

// each row holds a name, the program words, the preload address and word
// and the expected store address and data
task automatic fill_table();
    rows[0] = '{name: "add_sum",
        prog: '{addi_instr(1, 0, 100), addi_instr(2, 0, 23), add_instr(3, 1, 2),
                store_instr(3, 0, 32'h200), 0, 0, 0, 0},
        data_addr: 32'h3f0, data_word: 32'h0, exp_addr: 32'h200, exp_data: 32'h0000_007b};
    // sign extension of a negative immediate
    rows[1] = '{name: "addi_neg",
        prog: '{addi_instr(5, 0, -7), store_instr(5, 0, 32'h204), 0, 0, 0, 0, 0, 0},
        data_addr: 32'h3f0, data_word: 32'h0, exp_addr: 32'h204, exp_data: 32'hffff_fff9};
    rows[2] = '{name: "load_add",
        prog: '{addi_instr(2, 0, 32'h100), load_instr(4, 2, 32'h80), addi_instr(6, 4, 32'h55),
                store_instr(6, 2, 8), 0, 0, 0, 0},
        data_addr: 32'h180, data_word: 32'h1234_5000, exp_addr: 32'h108,
        exp_data: 32'h1234_5055};
    // two unknown opcodes in the middle
    rows[3] = '{name: "skip_unknown",
        prog: '{addi_instr(1, 0, 9), 32'hf0f0_1234, 32'h0000_0000, addi_instr(1, 1, 3),
                store_instr(1, 0, 32'h210), 0, 0, 0},
        data_addr: 32'h3f0, data_word: 32'h0, exp_addr: 32'h210, exp_data: 32'h0000_000c};
    rows[4] = '{name: "neg_offset",
        prog: '{addi_instr(9, 0, 32'h300), addi_instr(10, 0, 32'h7ff), store_instr(10, 9, -16),
                0, 0, 0, 0, 0},
        data_addr: 32'h3f0, data_word: 32'h0, exp_addr: 32'h2f0, exp_data: 32'h0000_07ff};
endtask

`endif

// File: bench/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu;

    localparam cpu_isa_pkg::word_t RESET_PC = 32'h0000_0040;
    localparam int NUM_REGS   = 32;
    localparam int CLK_PERIOD = 4;
    localparam int PASSES     = 2;
    localparam int MEM_WORDS  = 256;

    typedef struct {
        string              name;
        cpu_isa_pkg::word_t prog [8];
        cpu_isa_pkg::word_t data_addr;
        cpu_isa_pkg::word_t data_word;
        cpu_isa_pkg::word_t exp_addr;
        cpu_isa_pkg::word_t exp_data;
    } row_t;

    // one expected read request, fetch or load
    typedef struct {
        cpu_isa_pkg::word_t addr;
        bit                 fetch;
    } read_t;

    logic               clk       = 1'b0;
    logic               rst_n     = 1'b0;
    logic               mem_ack   = 1'b0;
    cpu_isa_pkg::word_t mem_rdata = '0;
    logic               mem_req;
    logic               mem_we;
    cpu_isa_pkg::word_t mem_addr;
    cpu_isa_pkg::word_t mem_wdata;

    cpu_isa_pkg::word_t mem [MEM_WORDS];
    read_t              exp_reads [$];
    int                 seed = 89210;
    bit                 rand_delay;
    bit                 pending;
    int                 wait_cnt;
    bit                 store_seen;
    cpu_isa_pkg::word_t store_addr;
    cpu_isa_pkg::word_t store_data;
    int                 checks;
    int                 errors;
    int                 tests_ok;
    int                 tests_bad;
    string              cur_name = "reset";

    function automatic cpu_isa_pkg::word_t encode(input cpu_isa_pkg::opcode_t op,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [12:0] imm);
        return {op, imm, rd, rs2, rs1};
    endfunction

    function automatic cpu_isa_pkg::word_t add_instr(input int rd, input int rs1, input int rs2);
        return encode(cpu_isa_pkg::op_add, rd, rs1, rs2, 0);
    endfunction

    function automatic cpu_isa_pkg::word_t addi_instr(input int rd, input int rs1, input int imm);
        return encode(cpu_isa_pkg::op_addi, rd, rs1, 0, imm);
    endfunction

    function automatic cpu_isa_pkg::word_t load_instr(input int rd, input int rs1, input int imm);
        return encode(cpu_isa_pkg::op_lw, rd, rs1, 0, imm);
    endfunction

    // rs2 holds the data, rs1 the base
    function automatic cpu_isa_pkg::word_t store_instr(input int rs2, input int rs1, input int imm);
        return encode(cpu_isa_pkg::op_sw, 0, rs1, rs2, imm);
    endfunction

    `include "tb_program.svh"

    cpu_top #(.RESET_PC(RESET_PC), .NUM_REGS(NUM_REGS)) u_dut (
        .clk(clk), .rst_n(rst_n),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_word(input string what, input cpu_isa_pkg::word_t want,
            input cpu_isa_pkg::word_t got);
        checks++;
        if (got !== want) begin
            $display("Error: %s %s: expected %h, actual %h", cur_name, what, want, got);
            errors++;
        end
    endtask

    task automatic compare_instr_addr(input cpu_isa_pkg::word_t want,
            input cpu_isa_pkg::word_t got);
        checks++;
        if (got !== want) begin
            $display("Error: %s fetch address: expected %h, actual %h", cur_name, want, got);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // memory model

    function automatic int ack_delay();
        if (!rand_delay)
            return 0;
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic serve_request();
        read_t want;
        int    idx;
        idx = mem_addr[9:2];
        if (mem_we) begin
            mem[idx] = mem_wdata;
            // only the first store of a program counts
            if (!store_seen) begin
                store_addr <= mem_addr;
                store_data <= mem_wdata;
            end
            store_seen <= 1'b1;
        end else begin
            mem_rdata <= mem[idx];
            if (!store_seen && exp_reads.size() == 0) begin
                $display("Error: %s read at %h after the program's last access",
                         cur_name, mem_addr);
                errors++;
            end else if (!store_seen) begin
                want = exp_reads.pop_front();
                if (want.fetch)
                    compare_instr_addr(want.addr, mem_addr);
                else
                    compare_word("load address", want.addr, mem_addr);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            if (mem_req) begin
                $display("Error: %s mem_req is high while reset is asserted", cur_name);
                errors++;
            end
            mem_ack    <= 1'b0;
            pending    <= 1'b0;
            store_seen <= 1'b0;
        end else if (mem_req && !mem_ack) begin
            if (!pending && ack_delay() == 0) begin
                mem_ack <= 1'b1;
                serve_request();
            end else if (!pending) begin
                pending  <= 1'b1;
                wait_cnt <= $unsigned($random(seed)) % 3;
            end else if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                pending <= 1'b0;
                mem_ack <= 1'b1;
                serve_request();
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // test loop

    // fill, program, preloaded word, then the reads the program must make
    task automatic load_memory(input int r);
        read_t       want;
        logic [3:0]  op;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'h5a00_0000 ^ (i * 4);
        for (int k = 0; k < 8; k++)
            mem[RESET_PC[9:2] + k] = rows[r].prog[k];
        mem[rows[r].data_addr[9:2]] = rows[r].data_word;
        exp_reads.delete();
        for (int k = 0; k < 8; k++) begin
            want.addr  = RESET_PC + 4 * k;
            want.fetch = 1'b1;
            exp_reads.push_back(want);
            op = rows[r].prog[k][31:28];
            if (op == cpu_isa_pkg::op_lw) begin
                want.addr  = rows[r].data_addr;
                want.fetch = 1'b0;
                exp_reads.push_back(want);
            end
            if (op == cpu_isa_pkg::op_sw)
                break;
        end
    endtask

    task automatic run_row(input int r);
        int errs_before;
        errs_before = errors;
        cur_name    = rows[r].name;
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        load_memory(r);
        repeat (15) @(posedge clk);
        rst_n <= 1'b1;
        while (!store_seen)
            @(posedge clk);
        compare_word("store address", rows[r].exp_addr, store_addr);
        compare_word("store data", rows[r].exp_data, store_data);
        if (exp_reads.size() != 0) begin
            $display("Error: %s stored before %0d expected reads were made",
                     cur_name, exp_reads.size());
            errors++;
        end
        if (errors == errs_before)
            tests_ok++;
        else
            tests_bad++;
        $display("%s (%s acks): %s", cur_name, rand_delay ? "random" : "fixed",
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        fill_table();
        for (int p = 0; p < PASSES; p++) begin
            rand_delay = (p != 0);
            for (int r = 0; r < NUM_ROWS; r++)
                run_row(r);
        end
        $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // at most 8 instructions per program, 40 cycles each
    initial begin
        #(PASSES * NUM_ROWS * 8 * 40 * CLK_PERIOD);
        $display("timeout in %s: the program never reached its store", cur_name);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: compile.f
+incdir+bench
verilog/cpu_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/ctrl_if.sv
verilog/micro_sequencer.sv
verilog/control_store.sv
verilog/datapath.sv
verilog/reg_file.sv
verilog/mem_port.sv
verilog/cpu_top.sv
bench/tb_cpu.sv
